// ==== rtl/ifu_consts.svh ====
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// Word and address width of the core.
`define IFU_XLEN 32

// First instruction fetched after reset.
`define IFU_PC_INIT 32'h8000_0000

// Cache geometry as log2 values.
`define IFU_L1I_SET_BITS 2
`define IFU_L1I_WORD_BITS 1

`define IFU_L1I_SETS (1 << `IFU_L1I_SET_BITS)
`define IFU_L1I_WORDS (1 << `IFU_L1I_WORD_BITS)

// Address split: byte offset, word in line, set index, then tag.
`define IFU_L1I_IDX_LSB (2 + `IFU_L1I_WORD_BITS)
`define IFU_L1I_TAG_LSB (`IFU_L1I_IDX_LSB + `IFU_L1I_SET_BITS)
`define IFU_L1I_TAG_BITS (`IFU_XLEN - `IFU_L1I_TAG_LSB)

// FENCE.I with all register and immediate fields zero.
`define IFU_INST_FENCE_I 32'h0000_100f

`endif

// ==== rtl/ifu_pkg.sv ====
package ifu_pkg;

  // Major opcodes that matter to fetch. Anything else is OP_OTHER.
  typedef enum logic [6:0] {
    OP_OTHER    = 7'b0000000,
    OP_LOAD     = 7'b0000011,
    OP_MISC_MEM = 7'b0001111,
    OP_BRANCH   = 7'b1100011,
    OP_JALR     = 7'b1100111,
    OP_JAL      = 7'b1101111,
    OP_SYSTEM   = 7'b1110011
  } opcode_e;

  // Line refill sequence of the instruction cache.
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_EVEN,
    FILL_ODD,
    FILL_DONE
  } fill_state_e;

  // Fetch either runs or waits for the execute side to resolve a hazard.
  typedef enum logic {
    FETCH_RUN,
    FETCH_STALL
  } fetch_state_e;

endpackage

// ==== rtl/l1i_cache.sv ====
`timescale 1ns/100ps
`include "ifu_consts.svh"

module l1i_cache (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`IFU_XLEN-1:0] fetch_pc_i,
  input  logic                 flush_i,
  output logic                 hit_o,
  output logic [`IFU_XLEN-1:0] hit_inst_o,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic [`IFU_XLEN-1:0] wb_adr_o,
  input  logic [`IFU_XLEN-1:0] wb_dat_i,
  input  logic                 wb_ack_i
);

  // Storage arrays.
  logic [`IFU_XLEN-1:0]         data_mem [`IFU_L1I_SETS][`IFU_L1I_WORDS];
  logic [`IFU_L1I_TAG_BITS-1:0] tag_mem  [`IFU_L1I_SETS];
  logic [`IFU_L1I_SETS-1:0]     valid_q;

  // Refill engine.
  ifu_pkg::fill_state_e                  fill_state_q;
  logic [`IFU_XLEN-1:`IFU_L1I_IDX_LSB]   fill_line_q;  // Line number of the refill.
  logic                                  wb_req_q;

  // Lookup address fields.
  logic [`IFU_L1I_TAG_BITS-1:0]  pc_tag;
  logic [`IFU_L1I_SET_BITS-1:0]  pc_idx;
  logic [`IFU_L1I_WORD_BITS-1:0] pc_off;

  // Refill address fields.
  logic [`IFU_L1I_TAG_BITS-1:0]  fill_tag;
  logic [`IFU_L1I_SET_BITS-1:0]  fill_idx;
  logic [`IFU_L1I_WORD_BITS-1:0] fill_off;

  logic fill_active;
  logic fill_busy;
  logic fill_start;
  logic word_ack;
  logic fill_last;

  assign pc_tag = fetch_pc_i[`IFU_XLEN-1:`IFU_L1I_TAG_LSB];
  assign pc_idx = fetch_pc_i[`IFU_L1I_TAG_LSB-1:`IFU_L1I_IDX_LSB];
  assign pc_off = fetch_pc_i[`IFU_L1I_IDX_LSB-1:2];

  assign fill_tag = fill_line_q[`IFU_XLEN-1:`IFU_L1I_TAG_LSB];
  assign fill_idx = fill_line_q[`IFU_L1I_TAG_LSB-1:`IFU_L1I_IDX_LSB];
  assign fill_off = (fill_state_q == ifu_pkg::FILL_ODD);  // Even word first.

  assign fill_active = (fill_state_q == ifu_pkg::FILL_EVEN) ||
                       (fill_state_q == ifu_pkg::FILL_ODD);

  // A set that is half written must not be read, whatever its old tag says.
  assign fill_busy = fill_active && (fill_idx == pc_idx);

  assign hit_o = valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag) && !fill_busy;
  assign hit_inst_o = data_mem[pc_idx][pc_off];

  assign fill_start = (fill_state_q == ifu_pkg::FILL_IDLE) && !hit_o;
  assign word_ack   = wb_req_q && wb_ack_i;
  assign fill_last  = word_ack && (fill_state_q == ifu_pkg::FILL_ODD);

  // Classic single reads, so cycle and strobe move together.
  assign wb_cyc_o = wb_req_q;
  assign wb_stb_o = wb_req_q;
  assign wb_adr_o = {fill_line_q, fill_off, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_state_q <= ifu_pkg::FILL_IDLE;
      wb_req_q     <= 1'b0;
    end else begin
      case (fill_state_q)
        ifu_pkg::FILL_IDLE: begin
          if (fill_start) begin
            fill_state_q <= ifu_pkg::FILL_EVEN;
            wb_req_q     <= 1'b1;
          end
        end
        ifu_pkg::FILL_EVEN: begin
          if (word_ack) begin
            fill_state_q <= ifu_pkg::FILL_ODD;
            wb_req_q     <= 1'b0;  // Bus idles one cycle between the two reads.
          end
        end
        ifu_pkg::FILL_ODD: begin
          if (!wb_req_q) begin
            wb_req_q <= 1'b1;
          end else if (wb_ack_i) begin
            fill_state_q <= ifu_pkg::FILL_DONE;
            wb_req_q     <= 1'b0;
          end
        end
        ifu_pkg::FILL_DONE: begin
          fill_state_q <= ifu_pkg::FILL_IDLE;
        end
        default: begin
          fill_state_q <= ifu_pkg::FILL_IDLE;
          wb_req_q     <= 1'b0;
        end
      endcase
    end
  end

  // A flush beats the final ack, so a line filled across a FENCE.I stays invalid.
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_last) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start) begin
      fill_line_q <= fetch_pc_i[`IFU_XLEN-1:`IFU_L1I_IDX_LSB];
    end
    if (word_ack) begin
      data_mem[fill_idx][fill_off] <= wb_dat_i;
    end
    // The captured tag is written even if fetch has been redirected meanwhile.
    if (fill_last) begin
      tag_mem[fill_idx] <= fill_tag;
    end
  end

endmodule

// ==== rtl/fetch_ctrl.sv ====
`timescale 1ns/100ps
`include "ifu_consts.svh"

module fetch_ctrl (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hit_i,
  input  logic [`IFU_XLEN-1:0] hit_inst_i,
  output logic [`IFU_XLEN-1:0] fetch_pc_o,
  output logic                 flush_o,
  output logic [`IFU_XLEN-1:0] inst_o,
  output logic [`IFU_XLEN-1:0] pc_o,
  output logic                 valid_o,
  input  logic                 ready_i,
  input  logic [`IFU_XLEN-1:0] npc_i,
  input  logic                 resume_i,
  input  logic                 redirect_i
);

  ifu_pkg::fetch_state_e state_q;
  ifu_pkg::opcode_e      op;
  logic [`IFU_XLEN-1:0]  pc_q;
  logic                  xfer;
  logic                  stall_inst;

  // Map the low seven bits onto the opcodes fetch cares about.
  always_comb begin
    case (hit_inst_i[6:0])
      ifu_pkg::OP_LOAD:     op = ifu_pkg::OP_LOAD;
      ifu_pkg::OP_MISC_MEM: op = ifu_pkg::OP_MISC_MEM;
      ifu_pkg::OP_BRANCH:   op = ifu_pkg::OP_BRANCH;
      ifu_pkg::OP_JALR:     op = ifu_pkg::OP_JALR;
      ifu_pkg::OP_JAL:      op = ifu_pkg::OP_JAL;
      ifu_pkg::OP_SYSTEM:   op = ifu_pkg::OP_SYSTEM;
      default:              op = ifu_pkg::OP_OTHER;
    endcase
  end

  // Control transfers and loads leave the next PC to the execute side.
  assign stall_inst = op inside {
    ifu_pkg::OP_JAL,
    ifu_pkg::OP_JALR,
    ifu_pkg::OP_BRANCH,
    ifu_pkg::OP_SYSTEM,
    ifu_pkg::OP_LOAD
  };

  // A redirect discards whatever is on offer in the same cycle.
  assign valid_o = (state_q == ifu_pkg::FETCH_RUN) && hit_i && !redirect_i;
  assign xfer    = valid_o && ready_i;

  assign inst_o     = hit_inst_i;
  assign pc_o       = pc_q;
  assign fetch_pc_o = pc_q;

  assign flush_o = xfer && (hit_inst_i == `IFU_INST_FENCE_I);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q    <= `IFU_PC_INIT;
      state_q <= ifu_pkg::FETCH_RUN;
    end else if (redirect_i) begin
      pc_q    <= npc_i;
      state_q <= ifu_pkg::FETCH_RUN;
    end else begin
      case (state_q)
        ifu_pkg::FETCH_RUN: begin
          if (xfer) begin
            if (stall_inst) begin
              state_q <= ifu_pkg::FETCH_STALL;  // PC stays until resume.
            end else begin
              pc_q <= pc_q + `IFU_XLEN'd4;
            end
          end
        end
        ifu_pkg::FETCH_STALL: begin
          if (resume_i) begin
            pc_q    <= npc_i;
            state_q <= ifu_pkg::FETCH_RUN;
          end
        end
        default: begin
          state_q <= ifu_pkg::FETCH_RUN;
        end
      endcase
    end
  end

endmodule

// ==== rtl/ifu_top.sv ====
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_top (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 wb_cyc_o,
  output logic                 wb_stb_o,
  output logic [`IFU_XLEN-1:0] wb_adr_o,
  input  logic [`IFU_XLEN-1:0] wb_dat_i,
  input  logic                 wb_ack_i,
  output logic [`IFU_XLEN-1:0] inst_o,
  output logic [`IFU_XLEN-1:0] pc_o,
  output logic                 valid_o,
  input  logic                 ready_i,
  input  logic [`IFU_XLEN-1:0] npc_i,
  input  logic                 resume_i,
  input  logic                 redirect_i
);

  logic [`IFU_XLEN-1:0] fetch_pc;
  logic                 flush;
  logic                 hit;
  logic [`IFU_XLEN-1:0] hit_inst;

  l1i_cache i_cache (
    .clk        (clk),
    .rst        (rst),
    .fetch_pc_i (fetch_pc),
    .flush_i    (flush),
    .hit_o      (hit),
    .hit_inst_o (hit_inst),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i)
  );

  fetch_ctrl i_fetch (
    .clk        (clk),
    .rst        (rst),
    .hit_i      (hit),
    .hit_inst_i (hit_inst),
    .fetch_pc_o (fetch_pc),
    .flush_o    (flush),
    .inst_o     (inst_o),
    .pc_o       (pc_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .npc_i      (npc_i),
    .resume_i   (resume_i),
    .redirect_i (redirect_i)
  );

endmodule

// ==== tests/ifu_props.sv ====
`timescale 1ns/100ps
`include "ifu_consts.svh"

module ifu_props (
  input logic                 clk,
  input logic                 rst,
  input logic                 wb_cyc_o,
  input logic                 wb_stb_o,
  input logic                 wb_ack_i,
  input logic [`IFU_XLEN-1:0] wb_adr_o,
  input logic                 valid_o,
  input logic                 ready_i,
  input logic [`IFU_XLEN-1:0] inst_o,
  input logic [`IFU_XLEN-1:0] pc_o
);

  // The master lets go of the bus for at least one cycle after each ack.
  bus_release: assert property (@(posedge clk) disable iff (rst)
    (wb_stb_o && wb_ack_i) |=> (!wb_cyc_o && !wb_stb_o))
    else $error("wb_cyc_o or wb_stb_o still high after ack");

  adr_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_stb_o && !wb_ack_i) |=> $stable(wb_adr_o))
    else $error("wb_adr_o changed before ack");

  // Decode sees the same offer until it takes it.
  offer_stable: assert property (@(posedge clk) disable iff (rst)
    (valid_o && !ready_i) |=> ($stable(inst_o) && $stable(pc_o)))
    else $error("inst_o or pc_o changed under back-pressure");

endmodule

bind ifu_top ifu_props i_props (
  .clk      (clk),
  .rst      (rst),
  .wb_cyc_o (wb_cyc_o),
  .wb_stb_o (wb_stb_o),
  .wb_ack_i (wb_ack_i),
  .wb_adr_o (wb_adr_o),
  .valid_o  (valid_o),
  .ready_i  (ready_i),
  .inst_o   (inst_o),
  .pc_o     (pc_o)
);

// ==== tests/tb_ifu.sv ====
`timescale 1ns/100ps
`include "ifu_consts.svh"

module tb_ifu;

  logic                 clk;
  logic                 rst;
  logic                 wb_cyc_o;
  logic                 wb_stb_o;
  logic [`IFU_XLEN-1:0] wb_adr_o;
  logic [`IFU_XLEN-1:0] wb_dat_i;
  logic                 wb_ack_i;
  logic [`IFU_XLEN-1:0] inst_o;
  logic [`IFU_XLEN-1:0] pc_o;
  logic                 valid_o;
  logic                 ready_i;
  logic [`IFU_XLEN-1:0] npc_i;
  logic                 resume_i;
  logic                 redirect_i;

  logic [31:0] mem [256];
  logic [31:0] read_cnt;
  logic [1:0]  ack_delay;

  ifu_top i_dut (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc_o   (wb_cyc_o),
    .wb_stb_o   (wb_stb_o),
    .wb_adr_o   (wb_adr_o),
    .wb_dat_i   (wb_dat_i),
    .wb_ack_i   (wb_ack_i),
    .inst_o     (inst_o),
    .pc_o       (pc_o),
    .valid_o    (valid_o),
    .ready_i    (ready_i),
    .npc_i      (npc_i),
    .resume_i   (resume_i),
    .redirect_i (redirect_i)
  );

  always #50 clk = ~clk;

  // Memory answers each strobe after 0 to 3 idle cycles.
  always @(posedge clk) begin
    if (rst) begin
      wb_ack_i  <= 1'b0;
      ack_delay <= 2'd0;
    end else if (wb_ack_i) begin
      wb_ack_i <= 1'b0;
    end else if (wb_stb_o) begin
      if (ack_delay == 2'd0) begin
        wb_ack_i  <= 1'b1;
        wb_dat_i  <= mem[wb_adr_o[9:2]];
        read_cnt  <= read_cnt + 32'd1;
        ack_delay <= 2'($urandom_range(0, 3));
      end else begin
        ack_delay <= ack_delay - 2'd1;
      end
    end
  end

  // ADDI with an immediate and rd taken from the word index.
  function automatic logic [31:0] addi_word(input logic [7:0] idx);
    return {4'ha, idx, 5'd0, 3'd0, idx[4:0], 7'h13};
  endfunction

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s got %h exp %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic wait_valid();
    int n;
    n = 0;
    @(negedge clk);
    while (!valid_o && n < 200) begin
      n++;
      @(negedge clk);
    end
    if (!valid_o) begin
      $display("Timeout: valid_o never arrived from the fetch stage");
      abort_run();
    end
  endtask

  task automatic wait_bus_busy();
    int n;
    n = 0;
    @(negedge clk);
    while (!wb_cyc_o && n < 200) begin
      n++;
      @(negedge clk);
    end
    if (!wb_cyc_o) begin
      $display("Timeout: the cache never started a Wishbone read");
      abort_run();
    end
  endtask

  // Check the offer, hold it for some cycles, then take it.
  task automatic take_inst(input logic [31:0] exp_pc, input int hold);
    wait_valid();
    check_eq("pc_o", pc_o, exp_pc);
    check_eq("inst_o", inst_o, mem[exp_pc[9:2]]);
    repeat (hold) begin
      @(negedge clk);
      check_eq("valid_o", {31'd0, valid_o}, 32'd1);
      check_eq("pc_o", pc_o, exp_pc);
      check_eq("inst_o", inst_o, mem[exp_pc[9:2]]);
    end
    @(posedge clk);
    ready_i <= 1'b1;
    @(posedge clk);
    ready_i <= 1'b0;
  endtask

  task automatic pulse_redirect(input logic [31:0] addr);
    @(posedge clk);
    redirect_i <= 1'b1;
    npc_i      <= addr;
    @(posedge clk);
    redirect_i <= 1'b0;
  endtask

  task automatic pulse_resume(input logic [31:0] addr);
    @(posedge clk);
    resume_i <= 1'b1;
    npc_i    <= addr;
    @(posedge clk);
    resume_i <= 1'b0;
  endtask

  task automatic expect_stalled();
    repeat (10) begin
      @(negedge clk);
      check_eq("valid_o", {31'd0, valid_o}, 32'd0);
    end
  endtask

  task automatic test_reset();
    repeat (3) begin
      @(negedge clk);
      check_eq("wb_cyc_o", {31'd0, wb_cyc_o}, 32'd0);
      check_eq("wb_stb_o", {31'd0, wb_stb_o}, 32'd0);
      check_eq("valid_o", {31'd0, valid_o}, 32'd0);
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_eq("wb_cyc_o", {31'd0, wb_cyc_o}, 32'd0);
    check_eq("valid_o", {31'd0, valid_o}, 32'd0);
  endtask

  task automatic test_sequential();
    for (int k = 0; k < 8; k++) begin
      take_inst(`IFU_PC_INIT + 32'(4 * k), 0);
      check_eq("read_cnt", read_cnt, 32'(2 * (k / 2 + 1)));
    end
  endtask

  // The PC after the eighth word maps onto set 0, so line 0 is replaced.
  task automatic test_hits();
    logic [31:0] base;
    wait_valid();
    base = read_cnt;
    pulse_redirect(`IFU_PC_INIT + 32'h8);
    take_inst(`IFU_PC_INIT + 32'h8, $urandom_range(1, 8));
    for (int k = 3; k < 9; k++) begin
      take_inst(`IFU_PC_INIT + 32'(4 * k), $urandom_range(0, 4));
    end
    check_eq("read_cnt", read_cnt, base);
  endtask

  task automatic test_stalls();
    pulse_redirect(`IFU_PC_INIT + 32'h40);
    take_inst(`IFU_PC_INIT + 32'h40, 0);  // JAL.
    expect_stalled();
    pulse_resume(`IFU_PC_INIT + 32'h44);
    take_inst(`IFU_PC_INIT + 32'h44, 0);  // Load.
    expect_stalled();
    pulse_resume(`IFU_PC_INIT + 32'h48);
    take_inst(`IFU_PC_INIT + 32'h48, 0);
  endtask

  task automatic test_fence();
    logic [31:0] base;
    pulse_redirect(`IFU_PC_INIT + 32'h50);
    take_inst(`IFU_PC_INIT + 32'h50, 0);
    take_inst(`IFU_PC_INIT + 32'h54, 0);
    wait_valid();  // Lets the refill of the next line finish.
    base = read_cnt;
    mem[20] = 32'h7ff0_0013;
    pulse_redirect(`IFU_PC_INIT + 32'h4c);
    take_inst(`IFU_PC_INIT + 32'h4c, 0);
    take_inst(`IFU_PC_INIT + 32'h50, 0);
    check_eq("read_cnt", read_cnt, base + 32'd2);
  endtask

  task automatic test_redirect_refill();
    pulse_redirect(`IFU_PC_INIT + 32'h80);
    wait_bus_busy();
    pulse_redirect(`IFU_PC_INIT + 32'h50);
    take_inst(`IFU_PC_INIT + 32'h50, 0);
  endtask

  initial begin
    void'($urandom(90));
    clk        = 1'b0;
    rst        = 1'b1;
    ready_i    = 1'b0;
    npc_i      = '0;
    resume_i   = 1'b0;
    redirect_i = 1'b0;
    wb_dat_i   = '0;
    wb_ack_i   = 1'b0;
    read_cnt   = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = addi_word(8'(i));
    end
    mem[16] = 32'h0000_006f;  // JAL x0, 0.
    mem[17] = 32'h0000_2003;  // LW x0, 0(x0).
    mem[19] = `IFU_INST_FENCE_I;

    test_reset();
    test_sequential();
    test_hits();
    test_stalls();
    test_fence();
    test_redirect_refill();

    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/ifu_pkg.sv
rtl/l1i_cache.sv
rtl/fetch_ctrl.sv
rtl/ifu_top.sv
tests/ifu_props.sv
tests/tb_ifu.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it.
verilator --binary --assert -f flist.f --top-module tb_ifu -Mdir obj_dir \
  && (./obj_dir/Vtb_ifu | grep -q "TEST PASSED") \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
